/* design/gpio_pkg.sv */
`default_nettype none

package gpio_pkg;

  // banks are whole 32-bit words covering the pin count of this instance
  localparam int unsigned GPIO_COUNT = 40;
  localparam int unsigned GPIO_BANKS = (GPIO_COUNT + 31) / 32;
  localparam int unsigned GPIO_BITS  = GPIO_BANKS * 32;

  // the bank selector inside the register block is at least one bit wide
  localparam int unsigned BANK_SEL_W = (GPIO_BANKS > 1) ? $clog2(GPIO_BANKS) : 1;

  // bits of the banked words that have a pin behind them
  localparam logic [GPIO_BITS-1:0] GPIO_IMPL_MASK = ~({GPIO_BITS{1'b1}} << GPIO_COUNT);

  // registers are word aligned within the byte address
  localparam int unsigned ADR_FUNC_LSB = 2;  // function in adr[3:2]
  localparam int unsigned ADR_BANK_LSB = 4;  // bank number in adr[9:4]
  localparam int unsigned ADR_BANK_W   = 6;

  // register function taken from adr[3:2]
  // the bank number comes from adr[9:4] and only banks below GPIO_BANKS exist
  typedef enum logic [1:0] {
    FUNC_IN  = 2'd0,  // read-only synchronized pin inputs
    FUNC_OUT = 2'd1,  // output value
    FUNC_OE  = 2'd2,  // output enable
    FUNC_DED = 2'd3   // dedicated select where 1 hands the pin to the peripheral
  } gpio_func_e;

  // master side of a classic Wishbone transfer
  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [3:0]  sel;
    logic [31:0] adr;
    logic [31:0] dat;
  } wb_req_t;

  // slave reply with exactly one of ack and err per transfer
  typedef struct packed {
    logic [31:0] dat;
    logic        ack;
    logic        err;
  } wb_rsp_t;

  // register state handed from the register block to the pad stage
  typedef struct packed {
    logic [GPIO_COUNT-1:0] out;
    logic [GPIO_COUNT-1:0] oe;
    logic [GPIO_COUNT-1:0] ded;
  } gpio_pins_t;

endpackage

`default_nettype wire

/* design/gpio_controller.sv */
`timescale 1ns/1ps
`default_nettype none

module gpio_controller
  import gpio_pkg::*;
(
  input  wire                   wb_clk_i,
  input  wire                   wb_rst_i,
  input  wire wb_req_t          wb_req_i,
  output wb_rsp_t               wb_rsp_o,
  input  wire  [GPIO_COUNT-1:0] sync_in_i,
  output gpio_pins_t            pins_o
);

  logic [ADR_BANK_W-1:0] bank;
  logic [BANK_SEL_W-1:0] bank_idx;
  gpio_func_e            func;
  logic                  bank_ok;
  logic                  req;
  logic                  bad_req;
  logic                  ack_q;
  logic                  err_q;
  logic [GPIO_BITS-1:0]  out_q;
  logic [GPIO_BITS-1:0]  oe_q;
  logic [GPIO_BITS-1:0]  ded_q;
  logic [GPIO_BITS-1:0]  in_ext;
  logic [31:0]           byte_mask;
  logic [31:0]           impl_word;
  logic [31:0]           rd_word;

  // merges the selected bytes of the write data into a stored word
  function automatic logic [31:0] merge_word(
    input logic [31:0] old_word,
    input logic [31:0] new_word,
    input logic [31:0] sel_mask,
    input logic [31:0] keep_mask
  );
    logic [31:0] merged;
    merged = (old_word & ~sel_mask) | (new_word & sel_mask);
    return merged & keep_mask;  // missing pins never get a bit set
  endfunction

  assign bank     = wb_req_i.adr[ADR_BANK_LSB +: ADR_BANK_W];
  assign func     = gpio_func_e'(wb_req_i.adr[ADR_FUNC_LSB +: 2]);
  assign bank_ok  = bank < ADR_BANK_W'(GPIO_BANKS);
  assign bank_idx = bank[BANK_SEL_W-1:0];  // only meaningful when bank_ok

  // a held stb is answered once, the cycle after it is first seen
  assign req     = wb_req_i.cyc && wb_req_i.stb && !ack_q && !err_q;
  assign bad_req = !bank_ok || (wb_req_i.we && (func == FUNC_IN));

  always_comb begin
    for (int b = 0; b < 4; b++) begin
      byte_mask[b*8 +: 8] = {8{wb_req_i.sel[b]}};
    end
  end

  assign impl_word = GPIO_IMPL_MASK[bank_idx*32 +: 32];

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      ack_q <= 1'b0;
      err_q <= 1'b0;
    end else begin
      ack_q <= req && !bad_req;
      err_q <= req && bad_req;  // err replaces ack
    end
  end

  // register writes land on the edge where ack rises
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      out_q <= '0;
      oe_q  <= '0;
      ded_q <= '0;  // every pin starts on GPIO and undriven
    end else if (req && wb_req_i.we && !bad_req) begin
      case (func)
        FUNC_OUT: begin
          out_q[bank_idx*32 +: 32] <= merge_word(out_q[bank_idx*32 +: 32], wb_req_i.dat,
                                                 byte_mask, impl_word);
        end
        FUNC_OE: begin
          oe_q[bank_idx*32 +: 32] <= merge_word(oe_q[bank_idx*32 +: 32], wb_req_i.dat,
                                                byte_mask, impl_word);
        end
        FUNC_DED: begin
          ded_q[bank_idx*32 +: 32] <= merge_word(ded_q[bank_idx*32 +: 32], wb_req_i.dat,
                                                 byte_mask, impl_word);
        end
        default: begin
        end
      endcase
    end
  end

  assign in_ext = GPIO_BITS'(sync_in_i);  // upper bits of the last bank read as zero

  // read data follows the address the master is still holding
  always_comb begin
    case (func)
      FUNC_IN:  rd_word = in_ext[bank_idx*32 +: 32];
      FUNC_OUT: rd_word = out_q[bank_idx*32 +: 32];
      FUNC_OE:  rd_word = oe_q[bank_idx*32 +: 32];
      default:  rd_word = ded_q[bank_idx*32 +: 32];
    endcase
    if (!bank_ok) begin
      rd_word = '0;
    end
  end

  assign wb_rsp_o.dat = rd_word;
  assign wb_rsp_o.ack = ack_q;
  assign wb_rsp_o.err = err_q;

  assign pins_o.out = out_q[GPIO_COUNT-1:0];
  assign pins_o.oe  = oe_q[GPIO_COUNT-1:0];
  assign pins_o.ded = ded_q[GPIO_COUNT-1:0];

  a_rsp_exclusive: assert property (
    @(posedge wb_clk_i) disable iff (wb_rst_i)
      !(wb_rsp_o.ack && wb_rsp_o.err)
  );

  // one response per transfer, even while the master still holds stb
  a_rsp_single_cycle: assert property (
    @(posedge wb_clk_i) disable iff (wb_rst_i)
      (wb_rsp_o.ack || wb_rsp_o.err) |=> !(wb_rsp_o.ack || wb_rsp_o.err)
  );

endmodule

`default_nettype wire

/* design/gpio_pad_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module gpio_pad_stage
  import gpio_pkg::*;
(
  input  wire                   wb_clk_i,
  input  wire                   wb_rst_i,
  input  wire gpio_pins_t       pins_i,
  input  wire  [GPIO_COUNT-1:0] ded_out_i,
  input  wire  [GPIO_COUNT-1:0] ded_oe_i,
  input  wire  [GPIO_COUNT-1:0] pad_in_i,
  output logic [GPIO_COUNT-1:0] pad_out_o,
  output logic [GPIO_COUNT-1:0] pad_oe_o,
  output logic [GPIO_COUNT-1:0] sync_in_o,
  output logic [GPIO_COUNT-1:0] ded_in_o
);

  logic [GPIO_COUNT-1:0] meta_q;
  logic [GPIO_COUNT-1:0] sync_q;

  // a set ded bit hands both value and enable of that pin to the peripheral
  assign pad_out_o = (pins_i.ded & ded_out_i) | (~pins_i.ded & pins_i.out);
  assign pad_oe_o  = (pins_i.ded & ded_oe_i)  | (~pins_i.ded & pins_i.oe);

  // pad inputs are asynchronous to wb_clk_i
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      meta_q <= '0;
      sync_q <= '0;
    end else begin
      meta_q <= pad_in_i;
      sync_q <= meta_q;  // stable two edges after the pad moved
    end
  end

  assign sync_in_o = sync_q;
  assign ded_in_o  = sync_q;  // the peripheral sees the same synchronized copy

  // floating pads must not leak X into the register block or the peripheral
  a_sync_known: assert property (
    @(posedge wb_clk_i) disable iff (wb_rst_i)
      !$isunknown(sync_q)
  );

endmodule

`default_nettype wire

/* design/gpio_subsystem.sv */
`timescale 1ns/1ps
`default_nettype none

module gpio_subsystem
  import gpio_pkg::*;
(
  input  wire                   wb_clk_i,
  input  wire                   wb_rst_i,
  input  wire                   wb_cyc_i,
  input  wire                   wb_stb_i,
  input  wire                   wb_we_i,
  input  wire  [3:0]            wb_sel_i,
  input  wire  [31:0]           wb_adr_i,
  input  wire  [31:0]           wb_dat_i,
  output logic [31:0]           wb_dat_o,
  output logic                  wb_ack_o,
  output logic                  wb_err_o,
  input  wire  [GPIO_COUNT-1:0] pad_in_i,
  output logic [GPIO_COUNT-1:0] pad_out_o,
  output logic [GPIO_COUNT-1:0] pad_oe_o,
  input  wire  [GPIO_COUNT-1:0] ded_out_i,
  input  wire  [GPIO_COUNT-1:0] ded_oe_i,
  output logic [GPIO_COUNT-1:0] ded_in_o
);

  wb_req_t               wb_req;
  wb_rsp_t               wb_rsp;
  gpio_pins_t            pins;
  logic [GPIO_COUNT-1:0] sync_in;

  assign wb_req = '{cyc: wb_cyc_i, stb: wb_stb_i, we: wb_we_i,
                    sel: wb_sel_i, adr: wb_adr_i, dat: wb_dat_i};

  assign wb_dat_o = wb_rsp.dat;
  assign wb_ack_o = wb_rsp.ack;
  assign wb_err_o = wb_rsp.err;

  gpio_controller i_controller (
    .wb_clk_i  (wb_clk_i),
    .wb_rst_i  (wb_rst_i),
    .wb_req_i  (wb_req),
    .wb_rsp_o  (wb_rsp),
    .sync_in_i (sync_in),
    .pins_o    (pins)
  );

  gpio_pad_stage i_pad_stage (
    .wb_clk_i  (wb_clk_i),
    .wb_rst_i  (wb_rst_i),
    .pins_i    (pins),
    .ded_out_i (ded_out_i),
    .ded_oe_i  (ded_oe_i),
    .pad_in_i  (pad_in_i),
    .pad_out_o (pad_out_o),
    .pad_oe_o  (pad_oe_o),
    .sync_in_o (sync_in),
    .ded_in_o  (ded_in_o)
  );

endmodule

`default_nettype wire

/* tests/gpio_tb_check.svh */
`ifndef GPIO_TB_CHECK_SVH
`define GPIO_TB_CHECK_SVH

// shadow copies of the banked registers and the pin levels last driven
logic [31:0]           model_out [GPIO_BANKS];
logic [31:0]           model_oe  [GPIO_BANKS];
logic [31:0]           model_ded [GPIO_BANKS];
logic [GPIO_COUNT-1:0] model_in = '0;
int                    check_count = 0;
int                    err_count = 0;

// bits of a bank word that have a pin behind them
function automatic logic [31:0] pin_mask(input int bank);
  logic [31:0] mask;
  for (int i = 0; i < 32; i++) begin
    mask[i] = (bank * 32 + i) < GPIO_COUNT;
  end
  return mask;
endfunction

function automatic bit bad_access(input int bank, input gpio_func_e func, input bit we);
  return (bank >= GPIO_BANKS) || (we && (func == FUNC_IN));
endfunction

function automatic logic [31:0] reg_word(input int bank, input gpio_func_e func);
  logic [31:0] word;
  word = '0;
  if (bank < GPIO_BANKS) begin
    case (func)
      FUNC_IN: begin
        for (int i = 0; i < 32; i++) begin
          if (bank * 32 + i < GPIO_COUNT) begin
            word[i] = model_in[bank * 32 + i];
          end
        end
      end
      FUNC_OUT: word = model_out[bank];
      FUNC_OE:  word = model_oe[bank];
      default:  word = model_ded[bank];
    endcase
  end
  return word;
endfunction

function automatic wb_rsp_t expected_rsp(input int bank, input gpio_func_e func, input bit we);
  wb_rsp_t rsp;
  rsp.err = bad_access(bank, func, we);
  rsp.ack = !rsp.err;
  rsp.dat = rsp.err ? 32'h0 : reg_word(bank, func);
  return rsp;
endfunction

task automatic apply_write(input int bank, input gpio_func_e func, input logic [3:0] sel,
                           input logic [31:0] dat);
  logic [31:0] word;
  if (!bad_access(bank, func, 1'b1)) begin  // rejected writes leave the model alone
    word = reg_word(bank, func);
    for (int b = 0; b < 4; b++) begin
      if (sel[b]) begin
        word[b*8 +: 8] = dat[b*8 +: 8];
      end
    end
    word = word & pin_mask(bank);
    case (func)
      FUNC_OUT: model_out[bank] = word;
      FUNC_OE:  model_oe[bank] = word;
      default:  model_ded[bank] = word;
    endcase
  end
endtask

// pad levels expected from the model, ded field unused
function automatic gpio_pins_t expected_pins(input logic [GPIO_COUNT-1:0] per_out,
                                             input logic [GPIO_COUNT-1:0] per_oe);
  gpio_pins_t pins;
  pins = '0;
  for (int p = 0; p < GPIO_COUNT; p++) begin
    if (model_ded[p / 32][p % 32]) begin
      pins.out[p] = per_out[p];
      pins.oe[p]  = per_oe[p];
    end else begin
      pins.out[p] = model_out[p / 32][p % 32];
      pins.oe[p]  = model_oe[p / 32][p % 32];
    end
  end
  return pins;
endfunction

task automatic rsp_compare(input string what, input wb_rsp_t exp, input wb_rsp_t got,
                           input bit with_dat);
  check_count++;
  if (got.ack !== exp.ack) begin
    err_count++;
    $display("Fail wb_ack_o (%s): expected %h, got %h", what, exp.ack, got.ack);
  end
  if (got.err !== exp.err) begin
    err_count++;
    $display("Fail wb_err_o (%s): expected %h, got %h", what, exp.err, got.err);
  end
  if (with_dat && (got.dat !== exp.dat)) begin
    err_count++;
    $display("Fail wb_dat_o (%s): expected %h, got %h", what, exp.dat, got.dat);
  end
endtask

task automatic pads_compare(input string what, input gpio_pins_t exp, input gpio_pins_t got);
  check_count++;
  if (got.out !== exp.out) begin
    err_count++;
    $display("Fail pad_out_o (%s): expected %h, got %h", what, exp.out, got.out);
  end
  if (got.oe !== exp.oe) begin
    err_count++;
    $display("Fail pad_oe_o (%s): expected %h, got %h", what, exp.oe, got.oe);
  end
endtask

task automatic vec_compare(input string what, input logic [GPIO_COUNT-1:0] exp,
                           input logic [GPIO_COUNT-1:0] got);
  check_count++;
  if (got !== exp) begin
    err_count++;
    $display("Fail %s: expected %h, got %h", what, exp, got);
  end
endtask

`endif

/* tests/tb_gpio_subsystem.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_gpio_subsystem
  import gpio_pkg::*;
();

  localparam int N_RW     = 200;
  localparam int N_PAD    = 40;
  localparam int N_IN     = 10;
  localparam int N_ERR    = 30;
  localparam int RSP_WAIT = 16;
  localparam int TOTAL_XFERS = 3 * GPIO_BANKS + 2 * N_RW + N_PAD + GPIO_BANKS * N_IN
                               + 2 * N_ERR + 4 * GPIO_BANKS;
  localparam int CYCLE_LIMIT = TOTAL_XFERS * 8 + 200;

  logic                  wb_clk_i;
  logic                  wb_rst_i;
  logic                  wb_cyc;
  logic                  wb_stb;
  logic                  wb_we;
  logic [3:0]            wb_sel;
  logic [31:0]           wb_adr;
  logic [31:0]           wb_dat;
  logic [31:0]           dut_dat;
  logic                  dut_ack;
  logic                  dut_err;
  logic [GPIO_COUNT-1:0] pad_in;
  logic [GPIO_COUNT-1:0] pad_out;
  logic [GPIO_COUNT-1:0] pad_oe;
  logic [GPIO_COUNT-1:0] ded_out;
  logic [GPIO_COUNT-1:0] ded_oe;
  logic [GPIO_COUNT-1:0] ded_in;
  integer                seed;
  int                    cycle_count = 0;

  `include "gpio_tb_check.svh"

  gpio_subsystem i_dut (
    .wb_clk_i  (wb_clk_i),
    .wb_rst_i  (wb_rst_i),
    .wb_cyc_i  (wb_cyc),
    .wb_stb_i  (wb_stb),
    .wb_we_i   (wb_we),
    .wb_sel_i  (wb_sel),
    .wb_adr_i  (wb_adr),
    .wb_dat_i  (wb_dat),
    .wb_dat_o  (dut_dat),
    .wb_ack_o  (dut_ack),
    .wb_err_o  (dut_err),
    .pad_in_i  (pad_in),
    .pad_out_o (pad_out),
    .pad_oe_o  (pad_oe),
    .ded_out_i (ded_out),
    .ded_oe_i  (ded_oe),
    .ded_in_o  (ded_in)
  );

  initial begin
    wb_clk_i = 1'b0;
    forever #5 wb_clk_i = ~wb_clk_i;
  end

  always @(posedge wb_clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("run stopped: tests did not finish within %0d cycles", CYCLE_LIMIT);
      $display("TEST FAIL");
      $finish;
    end
  end

  function automatic logic [GPIO_COUNT-1:0] random_pins();
    logic [63:0] r;
    r = {$random(seed), $random(seed)};
    return r[GPIO_COUNT-1:0];
  endfunction

  // one classic cycle, held until ack or err, sampled on the falling edge
  task automatic wb_transfer(input bit we, input int bank, input gpio_func_e func,
                             input logic [3:0] sel, input logic [31:0] dat,
                             output wb_rsp_t rsp);
    int waited;
    @(posedge wb_clk_i);
    wb_cyc <= 1'b1;
    wb_stb <= 1'b1;
    wb_we  <= we;
    wb_sel <= sel;
    wb_adr <= {22'd0, 6'(bank), func, 2'b00};
    wb_dat <= dat;
    waited = 0;
    rsp = '0;
    do begin
      @(negedge wb_clk_i);
      waited++;
    end while (!(dut_ack || dut_err) && waited < RSP_WAIT);
    if (dut_ack || dut_err) begin
      rsp = '{dat: dut_dat, ack: dut_ack, err: dut_err};
    end else begin
      err_count++;
      $display("no ack or err within %0d cycles for bank %0d func %0d", RSP_WAIT, bank, func);
    end
    @(posedge wb_clk_i);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  task automatic wb_write(input int bank, input gpio_func_e func, input logic [3:0] sel,
                          input logic [31:0] dat, output wb_rsp_t rsp);
    wb_transfer(1'b1, bank, func, sel, dat, rsp);
  endtask

  task automatic wb_read(input int bank, input gpio_func_e func, output wb_rsp_t rsp);
    wb_transfer(1'b0, bank, func, 4'hf, 32'h0, rsp);
  endtask

  task automatic report_test(input string name, input int errs_before);
    if (err_count == errs_before) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d errors", name, err_count - errs_before);
    end
  endtask

  // reads every stored register and compares it with the model
  task automatic readback_all(input string ctx);
    wb_rsp_t rsp;
    for (int b = 0; b < GPIO_BANKS; b++) begin
      for (int f = 1; f < 4; f++) begin
        wb_read(b, gpio_func_e'(f), rsp);
        rsp_compare($sformatf("%s bank %0d func %0d", ctx, b, f),
                    expected_rsp(b, gpio_func_e'(f), 1'b0), rsp, 1'b1);
      end
    end
  endtask

  task automatic reset_values();
    int errs;
    gpio_pins_t got;
    errs = err_count;
    readback_all("reset");
    @(negedge wb_clk_i);
    got = '{out: pad_out, oe: pad_oe, ded: '0};
    pads_compare("after reset", expected_pins(ded_out, ded_oe), got);
    report_test("reset values", errs);
  endtask

  task automatic register_readback();
    int errs;
    int bank;
    gpio_func_e func;
    logic [3:0] sel;
    logic [31:0] dat;
    wb_rsp_t rsp;
    errs = err_count;
    for (int i = 0; i < N_RW; i++) begin
      bank = $unsigned($random(seed)) % GPIO_BANKS;
      func = gpio_func_e'(1 + $unsigned($random(seed)) % 3);
      sel  = 4'($random(seed));
      dat  = $random(seed);
      wb_write(bank, func, sel, dat, rsp);
      rsp_compare($sformatf("write %0d", i), expected_rsp(bank, func, 1'b1), rsp, 1'b0);
      apply_write(bank, func, sel, dat);
      bank = $unsigned($random(seed)) % GPIO_BANKS;
      func = gpio_func_e'(1 + $unsigned($random(seed)) % 3);
      wb_read(bank, func, rsp);
      rsp_compare($sformatf("read %0d", i), expected_rsp(bank, func, 1'b0), rsp, 1'b1);
    end
    report_test("register write and read-back", errs);
  endtask

  task automatic pad_mux_sweep();
    int errs;
    int bank;
    gpio_func_e func;
    logic [3:0] sel;
    logic [31:0] dat;
    wb_rsp_t rsp;
    gpio_pins_t got;
    errs = err_count;
    @(posedge wb_clk_i);
    ded_out <= random_pins();  // peripheral lines stay put for the whole sweep
    ded_oe  <= random_pins();
    for (int i = 0; i < N_PAD; i++) begin
      bank = $unsigned($random(seed)) % GPIO_BANKS;
      func = gpio_func_e'(1 + $unsigned($random(seed)) % 3);
      sel  = 4'($random(seed));
      dat  = $random(seed);
      wb_write(bank, func, sel, dat, rsp);
      rsp_compare($sformatf("pad write %0d", i), expected_rsp(bank, func, 1'b1), rsp, 1'b0);
      apply_write(bank, func, sel, dat);
      @(negedge wb_clk_i);
      got = '{out: pad_out, oe: pad_oe, ded: '0};
      pads_compare($sformatf("pad write %0d", i), expected_pins(ded_out, ded_oe), got);
    end
    report_test("pad multiplexing", errs);
  endtask

  task automatic input_sync_sweep();
    int errs;
    logic [GPIO_COUNT-1:0] level;
    wb_rsp_t rsp;
    errs = err_count;
    for (int i = 0; i < N_IN; i++) begin
      level = random_pins();
      @(posedge wb_clk_i);
      pad_in <= level;
      model_in = level;
      repeat (3) @(posedge wb_clk_i);
      for (int b = 0; b < GPIO_BANKS; b++) begin
        wb_read(b, FUNC_IN, rsp);
        rsp_compare($sformatf("input %0d bank %0d", i, b), expected_rsp(b, FUNC_IN, 1'b0),
                    rsp, 1'b1);
      end
      @(negedge wb_clk_i);
      vec_compare("ded_in_o", model_in, ded_in);
    end
    report_test("input path", errs);
  endtask

  task automatic error_responses();
    int errs;
    int bank;
    gpio_func_e func;
    logic [3:0] sel;
    logic [31:0] dat;
    wb_rsp_t rsp;
    errs = err_count;
    for (int i = 0; i < N_ERR; i++) begin
      bank = GPIO_BANKS + $unsigned($random(seed)) % (64 - GPIO_BANKS);
      func = gpio_func_e'($unsigned($random(seed)) % 4);
      wb_read(bank, func, rsp);
      rsp_compare($sformatf("read bank %0d", bank), expected_rsp(bank, func, 1'b0), rsp, 1'b0);
      sel = 4'($random(seed));
      dat = $random(seed);
      wb_write(bank, func, sel, dat, rsp);
      rsp_compare($sformatf("write bank %0d", bank), expected_rsp(bank, func, 1'b1), rsp, 1'b0);
      apply_write(bank, func, sel, dat);
    end
    for (int b = 0; b < GPIO_BANKS; b++) begin
      dat = $random(seed);
      wb_write(b, FUNC_IN, 4'hf, dat, rsp);
      rsp_compare($sformatf("input write bank %0d", b), expected_rsp(b, FUNC_IN, 1'b1), rsp,
                  1'b0);
      apply_write(b, FUNC_IN, 4'hf, dat);
    end
    readback_all("after errors");
    report_test("error responses", errs);
  endtask

  initial begin
    seed     = 32'hf88d_7dff;
    wb_rst_i = 1'b1;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_sel   = 4'h0;
    wb_adr   = 32'h0;
    wb_dat   = 32'h0;
    pad_in   = '0;
    ded_out  = '0;
    ded_oe   = '0;
    for (int b = 0; b < GPIO_BANKS; b++) begin
      model_out[b] = '0;
      model_oe[b]  = '0;
      model_ded[b] = '0;
    end
    repeat (3) @(posedge wb_clk_i);
    wb_rst_i <= 1'b0;
    reset_values();
    register_readback();
    pad_mux_sweep();
    input_sync_sweep();
    error_responses();
    $display("checks %0d, errors %0d", check_count, err_count);
    if (err_count == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+tests
design/gpio_pkg.sv
design/gpio_controller.sv
design/gpio_pad_stage.sv
design/gpio_subsystem.sv
tests/tb_gpio_subsystem.sv

/* run_sim.sh */
#!/bin/sh
# builds the GPIO testbench with Verilator, runs it and looks for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f vlog.f \
  --top-module tb_gpio_subsystem -o sim_gpio \
  || { echo "verilator build failed"; exit 1; }
./obj_dir/sim_gpio | tee /dev/stderr | grep -q "TEST PASS" && exit 0 || exit 1
